// File: Bender.yml
package:
  name: octa_core

sources:
  - hdl/octaPkg.sv
  - hdl/octaControl.sv
  - hdl/fetchUnit.sv
  - hdl/regFile.sv
  - hdl/aluUnit.sv
  - hdl/branchCompare.sv
  - hdl/writeback.sv
  - hdl/octaCore.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/octaTb.sv

// File: hdl/aluUnit.sv
// Operand selection and ALU built around a two-nibble carry-lookahead adder

`timescale 1ns/1ps

module aluUnit #(
  parameter int imemAddrW = 4
) (
  input  octaPkg::dataT        r1,
  input  octaPkg::dataT        r2,
  input  octaPkg::dataT        imm,
  input  logic [imemAddrW-1:0] pc,
  input  octaPkg::aluOpE       aluOp,
  input  logic                 useImm,
  input  logic                 aluSrcPc,
  output octaPkg::dataT        result
);

  // 4-bit lookahead block, returns {carry out, sum}
  function automatic logic [4:0] cla4(input logic [3:0] a, input logic [3:0] b,
                                      input logic cin);
    logic [3:0] p;
    logic [3:0] g;
    logic [4:0] c;
    p    = a ^ b;
    g    = a & b;
    c[0] = cin;
    c[1] = g[0] | (p[0] & cin);
    c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
    c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
         | (p[3] & p[2] & p[1] & g[0]) | (p[3] & p[2] & p[1] & p[0] & cin);
    return {c[4], p ^ c[3:0]};
  endfunction

  octaPkg::dataT opA;
  octaPkg::dataT opB;
  octaPkg::dataT addB;
  logic          subMode;
  logic [4:0]    loNib;
  logic [4:0]    hiNib;

  assign opA     = aluSrcPc ? octaPkg::dataT'(pc) : r1;  // Zero-extended PC
  assign opB     = useImm ? imm : r2;
  assign subMode = (aluOp == octaPkg::aluSub) || (aluOp == octaPkg::aluSltu);
  assign addB    = subMode ? ~opB : opB;                 // Two's complement with cin
  assign loNib   = cla4(opA[3:0], addB[3:0], subMode);
  assign hiNib   = cla4(opA[7:4], addB[7:4], loNib[4]);

  always_comb begin
    case (aluOp)
      octaPkg::aluAdd,
      octaPkg::aluSub:  result = {hiNib[3:0], loNib[3:0]};
      octaPkg::aluNand: result = ~(opA & opB);
      octaPkg::aluNor:  result = ~(opA | opB);
      octaPkg::aluSltu: result = {7'd0, ~hiNib[4]};     // No carry out means A < B
      octaPkg::aluSll:  result = opA << opB[2:0];
      octaPkg::aluSrl:  result = opA >> opB[2:0];
      default:          result = $signed(opA) >>> opB[2:0];
    endcase
  end

endmodule

// File: hdl/branchCompare.sv
// Branch condition evaluation from a borrow-extended subtraction

`timescale 1ns/1ps

module branchCompare (
  input  octaPkg::dataT   r1,
  input  octaPkg::dataT   r2,
  input  octaPkg::branchE branchKind,
  output logic            condTrue
);

  logic [8:0] diff;
  logic       isEq;
  logic       isLtu;
  logic       isLt;

  assign diff  = {1'b0, r1} - {1'b0, r2};
  assign isEq  = (diff[7:0] == 8'd0);
  assign isLtu = diff[8];                               // Borrow out
  assign isLt  = (r1[7] ^ r2[7]) ? r1[7] : isLtu;       // Signs differ, negative one is less

  always_comb begin
    case (branchKind)
      octaPkg::brEq:  condTrue = isEq;
      octaPkg::brNe:  condTrue = ~isEq;
      octaPkg::brLt:  condTrue = isLt;
      octaPkg::brLtu: condTrue = isLtu;
      octaPkg::brGe:  condTrue = ~isLt;
      octaPkg::brGeu: condTrue = ~isLtu;
      default:        condTrue = 1'b0;
    endcase
  end

endmodule

// File: hdl/fetchUnit.sv
// Program counter, next-PC selection and loadable instruction memory

`timescale 1ns/1ps

module fetchUnit #(
  parameter int imemAddrW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 loadEn,
  input  logic [imemAddrW-1:0] loadAddr,
  input  octaPkg::instT        loadData,
  input  logic                 isBranch,
  input  logic                 isJump,
  input  logic                 condTrue,
  input  octaPkg::dataT        target,
  output logic [imemAddrW-1:0] pc,
  output logic [imemAddrW-1:0] pcNext,
  output octaPkg::instT        inst
);

  localparam int depth = 1 << imemAddrW;

  octaPkg::instT imem [depth];
  logic          takeTarget;

  // Program load only while the core is stopped
  always_ff @(posedge clk) begin
    if (loadEn && !run) begin
      imem[loadAddr] <= loadData;
    end
  end

  assign inst       = imem[pc];                     // Asynchronous read
  assign pcNext     = pc + imemAddrW'(1);
  assign takeTarget = isJump | (isBranch & condTrue);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;                                     // Restart from address 0
    end else begin
      pc <= takeTarget ? target[imemAddrW-1:0] : pcNext;
    end
  end

endmodule

// File: hdl/octaControl.sv
// Instruction field extraction, immediate generation and control decode

`timescale 1ns/1ps

module octaControl #(
  parameter int imemAddrW = 4
) (
  input  octaPkg::instT    inst,
  output octaPkg::regAddrT rs1,
  output octaPkg::regAddrT rs2,
  output octaPkg::regAddrT rd,
  output octaPkg::dataT    imm,
  output octaPkg::aluOpE   aluOp,
  output logic             useImm,
  output logic             aluSrcPc,
  output logic             isBranch,
  output logic             isJump,
  output octaPkg::branchE  branchKind,
  output logic             regWrite,
  output octaPkg::wbSelE   wbSel
);

  // Only the low PC-width bits of a jump offset reach the PC
  localparam octaPkg::dataT pcOffMask = octaPkg::dataT'((1 << imemAddrW) - 1);

  octaPkg::opcodeE opcode;
  logic [2:0]      func;
  octaPkg::dataT   iImm;
  octaPkg::dataT   bImm;
  octaPkg::dataT   jImm;

  assign opcode = octaPkg::opcodeE'(inst[2:0]);
  assign func   = inst[5:3];
  assign rd     = inst[8:6];
  assign rs1    = inst[11:9];
  assign rs2    = inst[14:12];

  assign iImm = {{5{inst[15]}}, inst[14:12]};  // Sign-extended 4 bits
  assign bImm = {{5{inst[15]}}, inst[8:6]};    // Branch offset in rd slot
  assign jImm = {1'b0, inst[15:9]};            // JAL offset, zero-extended

  always_comb begin
    imm        = iImm;
    aluOp      = octaPkg::aluAdd;
    useImm     = 1'b0;
    aluSrcPc   = 1'b0;
    isBranch   = 1'b0;
    isJump     = 1'b0;
    branchKind = octaPkg::brNever;
    regWrite   = 1'b0;
    wbSel      = octaPkg::wbAlu;
    case (opcode)
      octaPkg::opR: begin
        regWrite = 1'b1;
        aluOp    = octaPkg::aluOpE'(func);
      end
      octaPkg::opI: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        if (func == 3'd1) begin
          aluOp = octaPkg::aluAdd; // No SUBI, acts as ADDI
        end else begin
          aluOp = octaPkg::aluOpE'(func);
        end
      end
      octaPkg::opB: begin
        isBranch = 1'b1;
        aluSrcPc = 1'b1; // ALU forms PC + offset
        useImm   = 1'b1;
        imm      = bImm & pcOffMask;
        if (func >= 3'd6) begin
          branchKind = octaPkg::brNever;
        end else begin
          branchKind = octaPkg::branchE'(func);
        end
      end
      octaPkg::opJ: begin
        if (func == 3'd0) begin // JAL
          isJump   = 1'b1;
          regWrite = 1'b1;
          wbSel    = octaPkg::wbLink;
          aluSrcPc = 1'b1;
          useImm   = 1'b1;
          imm      = jImm & pcOffMask;
        end
      end
      default: begin
        regWrite = 1'b0; // Load, store, U-type and reserved do nothing
      end
    endcase
  end

endmodule

// File: hdl/octaCore.sv
// Core top level connecting control, fetch, register file, ALU, branch compare and writeback

`timescale 1ns/1ps

module octaCore #(
  parameter int imemAddrW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 loadEn,
  input  logic [imemAddrW-1:0] loadAddr,
  input  octaPkg::instT        loadData,
  output logic                 retireValid,
  output logic [imemAddrW-1:0] retirePc,
  output logic                 retireWrite,
  output octaPkg::regAddrT     retireReg,
  output octaPkg::dataT        retireData
);

  octaPkg::instT    inst;
  octaPkg::regAddrT rs1;
  octaPkg::regAddrT rs2;
  octaPkg::regAddrT rd;
  octaPkg::dataT    imm;
  octaPkg::aluOpE   aluOp;
  octaPkg::branchE  branchKind;
  octaPkg::wbSelE   wbSel;
  logic             useImm;
  logic             aluSrcPc;
  logic             isBranch;
  logic             isJump;
  logic             regWrite;
  logic             condTrue;
  octaPkg::dataT    r1;
  octaPkg::dataT    r2;
  octaPkg::dataT    aluResult;
  octaPkg::dataT    wdata;
  logic [imemAddrW-1:0] pc;
  logic [imemAddrW-1:0] pcNext;

  wire rfWrite = regWrite & run; // Registers only change on execute edges

  octaControl #(.imemAddrW(imemAddrW)) control0 (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .aluOp(aluOp), .useImm(useImm), .aluSrcPc(aluSrcPc),
    .isBranch(isBranch), .isJump(isJump), .branchKind(branchKind),
    .regWrite(regWrite), .wbSel(wbSel)
  );

  fetchUnit #(.imemAddrW(imemAddrW)) fetch0 (
    .clk(clk), .rst(rst), .run(run),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .isBranch(isBranch), .isJump(isJump), .condTrue(condTrue),
    .target(aluResult), .pc(pc), .pcNext(pcNext), .inst(inst)
  );

  regFile regs0 (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .regWrite(rfWrite), .wdata(wdata), .r1(r1), .r2(r2)
  );

  aluUnit #(.imemAddrW(imemAddrW)) alu0 (
    .r1(r1), .r2(r2), .imm(imm), .pc(pc), .aluOp(aluOp),
    .useImm(useImm), .aluSrcPc(aluSrcPc), .result(aluResult)
  );

  branchCompare cmp0 (
    .r1(r1), .r2(r2), .branchKind(branchKind), .condTrue(condTrue)
  );

  writeback #(.imemAddrW(imemAddrW)) wb0 (
    .clk(clk), .rst(rst), .run(run),
    .aluResult(aluResult), .pcNext(pcNext), .wbSel(wbSel),
    .regWrite(regWrite), .rd(rd), .pc(pc), .wdata(wdata),
    .retireValid(retireValid), .retirePc(retirePc), .retireWrite(retireWrite),
    .retireReg(retireReg), .retireData(retireData)
  );

endmodule

// File: hdl/octaPkg.sv
// Shared widths, data types and enums for opcodes, ALU ops, branch kinds and writeback select

package octaPkg;

  localparam int dataW    = 8;  // Register and ALU width
  localparam int instW    = 16; // Instruction word
  localparam int regAddrW = 3;  // Eight registers

  typedef logic [dataW-1:0]    dataT;
  typedef logic [instW-1:0]    instT;
  typedef logic [regAddrW-1:0] regAddrT;

  // Major opcode, instruction bits 2:0
  typedef enum logic [2:0] {
    opR     = 3'd0,
    opI     = 3'd1,
    opLoad  = 3'd2, // Not implemented, decodes as no-op
    opStore = 3'd3, // Not implemented, decodes as no-op
    opB     = 3'd4,
    opJ     = 3'd5,
    opU     = 3'd6, // Not implemented, decodes as no-op
    opRes   = 3'd7
  } opcodeE;

  // Order follows the R-type func field
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluNand = 3'd2,
    aluNor  = 3'd3,
    aluSltu = 3'd4,
    aluSll  = 3'd5,
    aluSrl  = 3'd6,
    aluSra  = 3'd7
  } aluOpE;

  // Order follows the B-type func field
  typedef enum logic [2:0] {
    brEq    = 3'd0,
    brNe    = 3'd1,
    brLt    = 3'd2,
    brLtu   = 3'd3,
    brGe    = 3'd4,
    brGeu   = 3'd5,
    brNever = 3'd6
  } branchE;

  typedef enum logic {
    wbAlu  = 1'b0,
    wbLink = 1'b1 // Return address PC+1
  } wbSelE;

endpackage

// File: hdl/regFile.sv
// Eight-entry register file, two read ports and one write port, r0 reads zero

`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  logic             rst,
  input  octaPkg::regAddrT rs1,
  input  octaPkg::regAddrT rs2,
  input  octaPkg::regAddrT rd,
  input  logic             regWrite,
  input  octaPkg::dataT    wdata,
  output octaPkg::dataT    r1,
  output octaPkg::dataT    r2
);

  localparam int numRegs = 1 << octaPkg::regAddrW;

  octaPkg::dataT regs [numRegs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (regWrite && (rd != '0)) begin
      regs[rd] <= wdata;                         // r0 never written
    end
  end

  // Index 0 is forced to zero on both read ports
  assign r1 = (rs1 == '0) ? '0 : regs[rs1];
  assign r2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/writeback.sv
// Register write data select and registered retire trace

`timescale 1ns/1ps

module writeback #(
  parameter int imemAddrW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  octaPkg::dataT        aluResult,
  input  logic [imemAddrW-1:0] pcNext,
  input  octaPkg::wbSelE       wbSel,
  input  logic                 regWrite,
  input  octaPkg::regAddrT     rd,
  input  logic [imemAddrW-1:0] pc,
  output octaPkg::dataT        wdata,
  output logic                 retireValid,
  output logic [imemAddrW-1:0] retirePc,
  output logic                 retireWrite,
  output octaPkg::regAddrT     retireReg,
  output octaPkg::dataT        retireData
);

  assign wdata = (wbSel == octaPkg::wbLink) ? octaPkg::dataT'(pcNext) : aluResult;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      retireValid <= 1'b0;
      retireWrite <= 1'b0;
    end else begin
      retireValid <= run;
      retireWrite <= run & regWrite & (rd != '0); // Real register update only
    end
  end

  // Trace payload
  always_ff @(posedge clk) begin
    if (run) begin
      retirePc   <= pc;
      retireReg  <= rd;
      retireData <= wdata;
    end
  end

endmodule

// File: sim.f
hdl/octaPkg.sv
hdl/octaControl.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/branchCompare.sv
hdl/writeback.sv
hdl/octaCore.sv
tests/tbClock.sv
tests/octaTb.sv

// File: tests/octaTb.sv
// Core testbench with LFSR random programs, instruction-set model, checks and timeout

`timescale 1ns/1ps

module octaTb;

  localparam int imemAddrW     = 4;
  localparam int imemDepth     = 1 << imemAddrW;
  localparam int numPrograms   = 8;
  localparam int runCycles     = 40;
  localparam int timeoutCycles = numPrograms * (imemDepth + 2 + runCycles) * 2;

  logic                 clk;
  logic                 rst;
  logic                 run;
  logic                 loadEn;
  logic [imemAddrW-1:0] loadAddr;
  logic [15:0]          loadData;
  logic                 retireValid;
  logic [imemAddrW-1:0] retirePc;
  logic                 retireWrite;
  logic [2:0]           retireReg;
  logic [7:0]           retireData;

  logic [15:0]          lfsrState;
  logic [7:0]           regModel [8];       // Architectural registers
  logic [15:0]          memModel [imemDepth];
  logic [imemAddrW-1:0] pcModel;
  int                   errorCount;
  int                   retiredCount;
  int                   cycleCount = 0;

  tbClock clockGen (.clk(clk), .rst(rst));

  octaCore #(.imemAddrW(imemAddrW)) dut0 (
    .clk(clk), .rst(rst), .run(run),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .retireValid(retireValid), .retirePc(retirePc), .retireWrite(retireWrite),
    .retireReg(retireReg), .retireData(retireData)
  );

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      val = {val[14:0], lfsrState[0]};
    end
  endtask

  function automatic logic [7:0] aluModel(input logic [2:0] fn, input logic [7:0] a,
                                          input logic [7:0] b);
    logic signed [7:0] sa;
    sa = a;
    case (fn)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return ~(a & b);
      3'd3: return ~(a | b);
      3'd4: return (a < b) ? 8'd1 : 8'd0;  // Unsigned compare
      3'd5: return a << b[2:0];
      3'd6: return a >> b[2:0];
      default: return sa >>> b[2:0];        // Sign fill
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] fn, input logic [7:0] a,
                                       input logic [7:0] b);
    case (fn)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd2: return $signed(a) < $signed(b);
      3'd3: return a < b;
      3'd4: return $signed(a) >= $signed(b);
      3'd5: return a >= b;
      default: return 1'b0;                 // Func 6 and 7
    endcase
  endfunction

  function automatic string instClass(input logic [15:0] ins);
    case (ins[2:0])
      3'd0: return "rtype";
      3'd1: return "itype";
      3'd4: return "branch";
      3'd5: return (ins[5:3] == 3'd0) ? "jal" : "noop";
      default: return "noop";
    endcase
  endfunction

  // Executes one instruction on the model state
  task automatic executeModel(input logic [15:0] ins, output logic wr,
                              output logic [2:0] rd, output logic [7:0] val);
    logic [2:0]           fn;
    logic [7:0]           a;
    logic [7:0]           b;
    logic [7:0]           immI;
    logic [7:0]           offB;
    logic [7:0]           offJ;
    logic [imemAddrW-1:0] link;
    logic [imemAddrW-1:0] nextPc;
    fn     = ins[5:3];
    rd     = ins[8:6];
    a      = regModel[ins[11:9]];
    b      = regModel[ins[14:12]];
    immI   = {{5{ins[15]}}, ins[14:12]};
    offB   = {{5{ins[15]}}, ins[8:6]};
    offJ   = {1'b0, ins[15:9]};
    link   = pcModel + 1'b1;
    nextPc = link;
    wr     = 1'b0;
    val    = '0;
    case (ins[2:0])
      3'd0: begin
        wr  = 1'b1;
        val = aluModel(fn, a, b);
      end
      3'd1: begin
        wr  = 1'b1;
        val = aluModel((fn == 3'd1) ? 3'd0 : fn, a, immI); // Func 1 is ADDI
      end
      3'd4: begin
        if (branchTaken(fn, a, b)) begin
          nextPc = pcModel + offB[imemAddrW-1:0];
        end
      end
      3'd5: begin
        if (fn == 3'd0) begin
          wr     = 1'b1;
          val    = {{(8 - imemAddrW){1'b0}}, link};
          nextPc = pcModel + offJ[imemAddrW-1:0];
        end
      end
      default: ;
    endcase
    if (rd == 3'd0) begin
      wr = 1'b0; // r0 stays zero
    end
    if (wr) begin
      regModel[rd] = val;
    end
    pcModel = nextPc;
  endtask

  task automatic reportMismatch(input string testName, input string field,
                                input logic [15:0] expected, input logic [15:0] actual);
    errorCount++;
    $display("FAILED %s %s expected 0x%0h actual 0x%0h", testName, field, expected, actual);
  endtask

  task automatic reportProblem(input string what);
    errorCount++;
    $display("Error: %s", what);
  endtask

  task automatic loadProgram();
    logic [15:0] word;
    for (int i = 0; i < imemDepth; i++) begin
      drawBits(16, word);
      memModel[i] = word;
      loadEn      = 1'b1;
      loadAddr    = i[imemAddrW-1:0];
      loadData    = word;
      @(negedge clk);
      if (retireValid !== 1'b0) begin
        reportProblem("retireValid is high while run is low");
      end
    end
    loadEn = 1'b0;
    @(negedge clk);
  endtask

  task automatic runProgram();
    logic [15:0]          ins;
    logic [imemAddrW-1:0] expPc;
    logic                 expWrite;
    logic [2:0]           expReg;
    logic [7:0]           expData;
    string                name;
    pcModel = '0;
    run     = 1'b1;
    for (int c = 0; c < runCycles; c++) begin
      @(negedge clk);
      ins   = memModel[pcModel];
      expPc = pcModel;
      name  = instClass(ins);
      executeModel(ins, expWrite, expReg, expData);
      retiredCount++;
      if (retireValid !== 1'b1) begin
        reportProblem("retireValid is low while the core is running");
      end
      if (retirePc !== expPc) begin
        reportMismatch(name, "retirePc", expPc, retirePc);
      end
      if (retireWrite !== expWrite) begin
        reportMismatch(name, "retireWrite", expWrite, retireWrite);
      end
      if (expWrite && retireReg !== expReg) begin
        reportMismatch(name, "retireReg", expReg, retireReg);
      end
      if (expWrite && retireData !== expData) begin
        reportMismatch(name, "retireData", expData, retireData);
      end
    end
    run = 1'b0;
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Timeout, the run did not end within %0d cycles", timeoutCycles);
      $display("Checked %0d retired instructions, %0d errors", retiredCount, errorCount);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    run          = 1'b0;
    loadEn       = 1'b0;
    loadAddr     = '0;
    loadData     = '0;
    lfsrState    = 16'd40;
    errorCount   = 0;
    retiredCount = 0;
    for (int r = 0; r < 8; r++) begin
      regModel[r] = '0;
    end
    @(negedge rst);
    @(negedge clk);
    if (retireValid !== 1'b0 || retireWrite !== 1'b0) begin
      reportProblem("retire outputs are not cleared by reset");
    end
    for (int p = 0; p < numPrograms; p++) begin
      loadProgram();
      runProgram();
    end
    @(negedge clk);
    if (retireValid !== 1'b0) begin
      reportProblem("retireValid stays high after run is dropped");
    end
    $display("Checked %0d retired instructions, %0d errors", retiredCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tests/tbClock.sv
// Testbench clock source and power-on reset sequence

`timescale 1ns/1ps

module tbClock #(
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // Released away from the active edge
  end

endmodule
